// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // register index width, x0..x31
  localparam int REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // major opcodes of the supported subset
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for OP / OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // SYSTEM immediate field
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

endpackage

`default_nettype wire

// ==== hw/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

  // sequencer states
  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1
  } state_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLL    = 4'd6,
    ALU_SRL    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_op_e;

  // register writeback source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LINK = 2'd1
  } wb_sel_e;

  // next-pc selection, fsm -> pc_unit
  localparam logic [2:0] PC_SEQ    = 3'd0;
  localparam logic [2:0] PC_BRANCH = 3'd1;
  localparam logic [2:0] PC_JUMP   = 3'd2;
  localparam logic [2:0] PC_TRAP   = 3'd3;
  localparam logic [2:0] PC_RET    = 3'd4;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import core_ctrl_pkg::*;
(
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        branch_ne,
  output logic [31:0] result,
  output logic        branch_taken
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      // signed compare
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // beq / bne condition
  assign branch_taken = (a == b) ^ branch_ne;

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
  import isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [REG_ADDR_W-1:0] raddr1,
  input  logic [REG_ADDR_W-1:0] raddr2,
  input  logic [REG_ADDR_W-1:0] dbg_addr,
  input  logic [31:0]           wdata,
  output logic [31:0]           rdata1,
  output logic [31:0]           rdata2,
  output logic [31:0]           dbg_data
);

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 stays at its reset value of zero
  assign rdata1   = regs[raddr1];
  assign rdata2   = regs[raddr2];
  assign dbg_data = regs[dbg_addr];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    regs[0] == '0);

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic [31:0]           instr,
  output alu_op_e               alu_op,
  output logic [31:0]           imm,
  output logic [REG_ADDR_W-1:0] rs1,
  output logic [REG_ADDR_W-1:0] rs2,
  output logic [REG_ADDR_W-1:0] rd,
  output logic                  use_imm,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_ecall,
  output logic                  is_mret,
  output logic                  illegal,
  output logic                  reg_wr_req,
  output wb_sel_e               wb_sel,
  output logic                  branch_ne
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op     = ALU_ADD;
    imm        = imm_i;
    use_imm    = 1'b0;
    is_branch  = 1'b0;
    is_jal     = 1'b0;
    is_ecall   = 1'b0;
    is_mret    = 1'b0;
    illegal    = 1'b0;
    reg_wr_req = 1'b0;
    wb_sel     = WB_ALU;
    branch_ne  = 1'b0;
    case (opcode)
      OP: begin
        reg_wr_req = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = (funct7 == 7'h20) ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_op = ALU_SLL;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_SRL:  alu_op = ALU_SRL;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
        // only sub carries a nonzero funct7
        if (funct7 != 7'h00 && !(funct3 == F3_ADD && funct7 == 7'h20)) begin
          illegal = 1'b1;
        end
      end
      OP_IMM: begin
        reg_wr_req = 1'b1;
        use_imm    = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      LUI: begin
        reg_wr_req = 1'b1;
        use_imm    = 1'b1;
        imm        = imm_u;
        alu_op     = ALU_PASS_B;
      end
      BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        branch_ne = (funct3 == F3_BNE);
        illegal   = !is_branch;
      end
      JAL: begin
        imm        = imm_j;
        is_jal     = 1'b1;
        reg_wr_req = 1'b1;
        wb_sel     = WB_LINK;
      end
      SYSTEM: begin
        if (funct3 == 3'b000 && rd == '0 && rs1 == '0) begin
          is_ecall = (instr[31:20] == FUNCT12_ECALL);
          is_mret  = (instr[31:20] == FUNCT12_MRET);
        end
        illegal = !(is_ecall || is_mret);
      end
      default: illegal = 1'b1;
    endcase
    // illegal encodings never write back
    if (illegal) begin
      reg_wr_req = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit
  import core_ctrl_pkg::*;
#(
  parameter logic [31:0] RESET_PC    = 32'h0000_0000,
  parameter logic [31:0] TRAP_VECTOR = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        exec_en,
  input  logic [2:0]  pc_sel,
  input  logic [31:0] imm,
  output logic [31:0] pc,
  output logic [31:0] link
);

  // pc of the trapping instruction
  logic [31:0] epc;

  assign link = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (exec_en) begin
      case (pc_sel)
        PC_BRANCH, PC_JUMP: pc <= pc + imm;
        PC_TRAP:            pc <= TRAP_VECTOR;
        PC_RET:             pc <= epc + 32'd4;
        default:            pc <= link;
      endcase
    end
  end

  // save point for mret
  always_ff @(posedge clk) begin
    if (exec_en && (pc_sel == PC_TRAP)) begin
      epc <= pc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fsm
  import core_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       debug,
  input  logic       is_branch,
  input  logic       branch_taken,
  input  logic       is_jal,
  input  logic       is_ecall,
  input  logic       is_mret,
  input  logic       illegal,
  input  logic       reg_wr_req,
  output logic       fetch_en,
  output logic       exec_en,
  output logic       reg_we,
  output logic       retire,
  output logic       trapping,
  output logic [2:0] pc_sel
);

  state_e state;
  state_e state_next;
  logic   trap_enter;
  logic   trap_return;

  ////////////////////////////////////////////////////////////
  // fetch / execute sequencing
  ////////////////////////////////////////////////////////////

  // debug holds us in fetch, an exec already running finishes
  assign fetch_en = (state == S_FETCH) && !debug;
  assign exec_en  = (state == S_EXEC);

  always_comb begin
    state_next = S_FETCH;
    if (fetch_en) begin
      state_next = S_EXEC;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // trap level and pc selection
  ////////////////////////////////////////////////////////////

  // nested ecall and stray mret fall through as no-ops
  assign trap_enter  = (is_ecall || illegal) && !trapping;
  assign trap_return = is_mret && trapping;

  always_comb begin
    pc_sel = PC_SEQ;
    if (trap_enter) begin
      pc_sel = PC_TRAP;
    end else if (trap_return) begin
      pc_sel = PC_RET;
    end else if (is_jal) begin
      pc_sel = PC_JUMP;
    end else if (is_branch && branch_taken) begin
      pc_sel = PC_BRANCH;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trapping <= 1'b0;
    end else if (exec_en) begin
      if (trap_enter) begin
        trapping <= 1'b1;
      end else if (trap_return) begin
        trapping <= 1'b0;
      end
    end
  end

  // writes only in exec, never on trap entry
  assign reg_we = exec_en && reg_wr_req && !trap_enter;
  assign retire = exec_en;

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {S_FETCH, S_EXEC});

  a_fetch_exec_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(fetch_en && exec_en));

endmodule

`default_nettype wire

// ==== hw/riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core
  import isa_pkg::*;
  import core_ctrl_pkg::*;
#(
  parameter logic [31:0] RESET_PC    = 32'h0000_0000,
  parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  debug,
  input  logic [REG_ADDR_W-1:0] debug_addr,
  input  logic [31:0]           imem_data,
  output logic [31:0]           imem_addr,
  output logic [31:0]           debug_data,
  output logic                  trapping,
  output logic                  retire
);

  logic                  fetch_en;
  logic                  exec_en;
  logic                  reg_we;
  logic [2:0]            pc_sel;
  logic [31:0]           instr_q;
  logic [31:0]           pc;
  logic [31:0]           link;
  alu_op_e               alu_op;
  wb_sel_e               wb_sel;
  logic [31:0]           imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  use_imm;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_ecall;
  logic                  is_mret;
  logic                  illegal;
  logic                  reg_wr_req;
  logic                  branch_ne;
  logic                  branch_taken;
  logic [31:0]           rs1_data;
  logic [31:0]           rs2_data;
  logic [31:0]           dbg_rdata;
  logic [31:0]           alu_b;
  logic [31:0]           alu_result;
  logic [31:0]           wb_data;

  assign imem_addr = pc;

  // instruction latch
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      instr_q <= imem_data;
    end
  end

  assign alu_b   = use_imm ? imm : rs2_data;
  assign wb_data = (wb_sel == WB_LINK) ? link : alu_result;

  ////////////////////////////////////////////////////////////
  // debug readout, one cycle behind debug_addr
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      debug_data <= '0;
    end else if (debug) begin
      debug_data <= (debug_addr == '0) ? pc : dbg_rdata;
    end else begin
      debug_data <= '0;
    end
  end

  core_fsm u_fsm (
    .clk, .rst_n, .debug, .is_branch, .branch_taken, .is_jal, .is_ecall,
    .is_mret, .illegal, .reg_wr_req, .fetch_en, .exec_en, .reg_we,
    .retire, .trapping, .pc_sel
  );

  pc_unit #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) u_pc (
    .clk, .rst_n, .exec_en, .pc_sel, .imm, .pc, .link
  );

  instr_decoder u_dec (
    .instr(instr_q), .alu_op, .imm, .rs1, .rs2, .rd, .use_imm, .is_branch,
    .is_jal, .is_ecall, .is_mret, .illegal, .reg_wr_req, .wb_sel, .branch_ne
  );

  alu u_alu (
    .op(alu_op), .a(rs1_data), .b(alu_b), .branch_ne,
    .result(alu_result), .branch_taken
  );

  regfile u_rf (
    .clk, .rst_n, .we(reg_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
    .dbg_addr(debug_addr), .wdata(wb_data), .rdata1(rs1_data),
    .rdata2(rs2_data), .dbg_data(dbg_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/tb_riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core
  import isa_pkg::*;
();

  localparam logic [31:0] RESET_PC    = 32'h0000_0040;
  localparam logic [31:0] TRAP_VECTOR = 32'h0000_0100;
  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DLY     = 1;
  localparam int RESET_CYCLES  = 8;
  localparam int FREEZE_CYCLES = 20;
  localparam int BASE          = RESET_PC[9:2];
  localparam int TRAP_BASE     = TRAP_VECTOR[9:2];

  // retires per test add up as 14 + 8 + 13 + 8
  localparam int TOTAL_RETIRES   = 43;
  localparam int NUM_TESTS       = 5;
  localparam int READ_CYCLES     = 40;
  localparam int MARGIN_CYCLES   = 100;
  localparam int WATCHDOG_CYCLES = TOTAL_RETIRES * 2 + NUM_TESTS * (RESET_CYCLES + 2)
                                   + READ_CYCLES + FREEZE_CYCLES + MARGIN_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        debug;
  logic [4:0]  debug_addr;
  logic [31:0] imem_data;
  logic [31:0] imem_addr;
  logic [31:0] debug_data;
  logic        trapping;
  logic        retire;

  logic [31:0] imem [256];
  int          errors;
  int          checks;

  riscv_core #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) u_dut (
    .clk, .rst_n, .debug, .debug_addr, .imem_data, .imem_addr, .debug_data,
    .trapping, .retire
  );

  // asynchronous instruction read
  assign imem_data = imem[imem_addr[9:2]];

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] enc_i(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_u(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, LUI};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  function automatic logic [31:0] enc_sys(logic [11:0] f12);
    return {f12, 5'd0, 3'b000, 5'd0, SYSTEM};
  endfunction

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // each word holds a distinct nop that adds its index to x0
  task automatic fill_imem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(OP_IMM, F3_ADD, 5'd0, 5'd0, 12'(i));
    end
  endtask

  task automatic place(int idx, logic [31:0] word);
    imem[idx[7:0]] = word;
  endtask

  task automatic check_value(string msg, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s: got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    debug = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  endtask

  task automatic wait_retires(int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk);
      if (retire) begin
        seen++;
      end
    end
  endtask

  // hold the core in fetch after the current instruction
  task automatic freeze();
    @(posedge clk);
    #DRIVE_DLY;
    debug = 1'b1;
  endtask

  task automatic check_reg(logic [4:0] idx, logic [31:0] exp, string msg);
    debug_addr = idx;
    @(posedge clk);
    #DRIVE_DLY;
    check_value(msg, debug_data, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset();
    fill_imem();
    apply_reset();
    check_value("trapping after reset", {31'd0, trapping}, 32'd0);
    check_value("retire after reset", {31'd0, retire}, 32'd0);
    debug = 1'b1;
    check_reg(5'd0, RESET_PC, "pc after reset");
    debug = 1'b0;
    @(posedge clk);
    #DRIVE_DLY;
    check_value("debug_data with debug low", debug_data, 32'd0);
  endtask

  task automatic test_arith();
    fill_imem();
    place(BASE + 0, enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd12));
    // x2 = -5
    place(BASE + 1, enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'hffb));
    place(BASE + 2, enc_r(7'h00, F3_ADD, 5'd3, 5'd1, 5'd2));
    place(BASE + 3, enc_r(7'h20, F3_ADD, 5'd4, 5'd1, 5'd2));
    place(BASE + 4, enc_r(7'h00, F3_AND, 5'd5, 5'd1, 5'd2));
    place(BASE + 5, enc_r(7'h00, F3_OR, 5'd6, 5'd1, 5'd2));
    place(BASE + 6, enc_r(7'h00, F3_XOR, 5'd7, 5'd1, 5'd2));
    place(BASE + 7, enc_r(7'h00, F3_SLT, 5'd8, 5'd2, 5'd1));
    place(BASE + 8, enc_r(7'h00, F3_SLT, 5'd9, 5'd1, 5'd2));
    place(BASE + 9, enc_i(OP_IMM, F3_ADD, 5'd10, 5'd0, 12'd3));
    place(BASE + 10, enc_r(7'h00, F3_SLL, 5'd11, 5'd1, 5'd10));
    place(BASE + 11, enc_r(7'h00, F3_SRL, 5'd12, 5'd2, 5'd10));
    place(BASE + 12, enc_i(OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd5));
    // x13 = x0 + x1 shows x0 is still zero
    place(BASE + 13, enc_r(7'h00, F3_ADD, 5'd13, 5'd0, 5'd1));
    apply_reset();
    wait_retires(14);
    freeze();
    check_reg(5'd1, 32'd12, "addi x1");
    check_reg(5'd2, 32'hffff_fffb, "addi x2 negative");
    check_reg(5'd3, 32'd7, "add");
    check_reg(5'd4, 32'd17, "sub");
    check_reg(5'd5, 32'd8, "and");
    check_reg(5'd6, 32'hffff_ffff, "or");
    check_reg(5'd7, 32'hffff_fff7, "xor");
    check_reg(5'd8, 32'd1, "slt negative less");
    check_reg(5'd9, 32'd0, "slt positive not less");
    check_reg(5'd11, 32'd96, "sll");
    check_reg(5'd12, 32'h1fff_ffff, "srl");
    check_reg(5'd13, 32'd12, "x0 after write");
  endtask

  task automatic test_control();
    fill_imem();
    place(BASE + 0, enc_u(5'd1, 20'h12345));
    place(BASE + 1, enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd7));
    place(BASE + 2, enc_i(OP_IMM, F3_ADD, 5'd3, 5'd0, 12'd7));
    place(BASE + 3, enc_b(F3_BEQ, 5'd2, 5'd3, 13'd8));
    place(BASE + 4, enc_i(OP_IMM, F3_ADD, 5'd4, 5'd0, 12'd99));
    place(BASE + 5, enc_b(F3_BNE, 5'd2, 5'd3, 13'd8));
    place(BASE + 6, enc_i(OP_IMM, F3_ADD, 5'd5, 5'd0, 12'd1));
    place(BASE + 7, enc_j(5'd6, 21'd12));
    place(BASE + 8, enc_i(OP_IMM, F3_ADD, 5'd7, 5'd0, 12'd55));
    place(BASE + 9, enc_i(OP_IMM, F3_ADD, 5'd7, 5'd0, 12'd66));
    place(BASE + 10, enc_i(OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd2));
    apply_reset();
    wait_retires(8);
    freeze();
    check_reg(5'd1, 32'h1234_5000, "lui");
    check_reg(5'd4, 32'd0, "beq skipped write");
    check_reg(5'd5, 32'd1, "bne fall-through");
    check_reg(5'd6, RESET_PC + 32'd32, "jal link");
    check_reg(5'd7, 32'd0, "jal skipped writes");
    check_reg(5'd8, 32'd2, "jal target");
    check_reg(5'd0, RESET_PC + 32'd44, "pc after control flow");
  endtask

  task automatic test_trap();
    fill_imem();
    place(BASE + 0, enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd1));
    place(BASE + 1, enc_sys(FUNCT12_ECALL));
    place(BASE + 2, enc_i(OP_IMM, F3_ADD, 5'd4, 5'd0, 12'd4));
    // reserved major opcode
    place(BASE + 3, 32'h0000_007f);
    place(BASE + 4, enc_i(OP_IMM, F3_ADD, 5'd5, 5'd0, 12'd5));
    // trap handler with a nested ecall and a visit counter in x3
    place(TRAP_BASE + 0, enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd2));
    place(TRAP_BASE + 1, enc_sys(FUNCT12_ECALL));
    place(TRAP_BASE + 2, enc_i(OP_IMM, F3_ADD, 5'd3, 5'd3, 12'd1));
    place(TRAP_BASE + 3, enc_sys(FUNCT12_MRET));
    apply_reset();
    wait_retires(2);
    @(posedge clk);
    #DRIVE_DLY;
    check_value("trapping after ecall", {31'd0, trapping}, 32'd1);
    check_value("fetch after ecall", imem_addr, TRAP_VECTOR);
    wait_retires(4);
    @(posedge clk);
    #DRIVE_DLY;
    check_value("trapping after mret", {31'd0, trapping}, 32'd0);
    check_value("fetch after mret", imem_addr, RESET_PC + 32'd8);
    wait_retires(2);
    @(posedge clk);
    #DRIVE_DLY;
    check_value("trapping after illegal", {31'd0, trapping}, 32'd1);
    check_value("fetch after illegal", imem_addr, TRAP_VECTOR);
    wait_retires(5);
    freeze();
    check_reg(5'd1, 32'd1, "before ecall");
    check_reg(5'd2, 32'd2, "handler write");
    check_reg(5'd3, 32'd2, "handler visits");
    check_reg(5'd4, 32'd4, "resume after ecall");
    check_reg(5'd5, 32'd5, "resume after illegal");
    check_reg(5'd0, RESET_PC + 32'd20, "pc after traps");
  endtask

  task automatic test_freeze();
    int stray;
    stray = 0;
    fill_imem();
    place(BASE + 0, enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd1));
    for (int k = 1; k < 8; k++) begin
      place(BASE + k, enc_i(OP_IMM, F3_ADD, 5'd1, 5'd1, 12'd1));
    end
    apply_reset();
    wait_retires(3);
    freeze();
    check_reg(5'd1, 32'd3, "x1 at freeze");
    check_reg(5'd0, RESET_PC + 32'd12, "pc at freeze");
    repeat (FREEZE_CYCLES) begin
      @(negedge clk);
      if (retire) begin
        stray++;
      end
    end
    check_value("retires while frozen", 32'(stray), 32'd0);
    @(posedge clk);
    #DRIVE_DLY;
    check_reg(5'd1, 32'd3, "x1 held by freeze");
    check_reg(5'd0, RESET_PC + 32'd12, "pc held by freeze");
    @(posedge clk);
    #DRIVE_DLY;
    debug = 1'b0;
    wait_retires(5);
    freeze();
    check_reg(5'd1, 32'd8, "x1 after release");
    check_reg(5'd0, RESET_PC + 32'd32, "pc after release");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    debug      = 1'b0;
    debug_addr = '0;
    errors     = 0;
    checks     = 0;
    fill_imem();
    test_reset();
    test_arith();
    test_control();
    test_trap();
    test_freeze();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the core did not retire the expected instructions in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/instr_decoder.sv
hw/pc_unit.sv
hw/core_fsm.sv
hw/riscv_core.sv
dv/tb_riscv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_riscv_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
